// ==== build.f ====
+incdir+.
ctrlPkg.sv
instrFetch.sv
instrDecode.sv
execSequencer.sv
resultStage.sv
ctrlTop.sv
tbCtrlTop.sv

// ==== ctrlPkg.sv ====
`default_nettype none

package ctrlPkg;

    // Primary opcodes still decoded
    typedef enum logic [5:0] {
        opSpecial = 6'b000000,
        opAddi    = 6'b001000,
        opAddiu   = 6'b001001
    } opcodeT;

    // Funct codes under opSpecial
    typedef enum logic [5:0] {
        fnAdd  = 6'b100000,
        fnSub  = 6'b100010,
        fnAnd  = 6'b100100,
        fnSlt  = 6'b101010,
        fnMult = 6'b011000,
        fnDiv  = 6'b011010,
        fnJr   = 6'b001000,
        fnMfhi = 6'b010000,
        fnMflo = 6'b010010
    } functT;

    typedef struct packed {
        opcodeT     opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        functT      funct;
    } instrT;

    // ALU operation select, same encoding as the datapath ALU
    typedef enum logic [2:0] {
        aluPass = 3'b000,
        aluAdd  = 3'b001,
        aluSub  = 3'b010,
        aluAnd  = 3'b011,
        aluSlt  = 3'b111
    } aluOpT;

    typedef enum logic {
        srcAPc   = 1'b0,
        srcARegA = 1'b1
    } aluSrcAT;

    typedef enum logic [1:0] {
        srcBRegB    = 2'b00,
        srcBFour    = 2'b01,
        srcBSignImm = 2'b10
    } aluSrcBT;

    typedef enum logic [1:0] {
        pcSrcAluResult = 2'b00,
        pcSrcExcVector = 2'b01
    } pcSrcT;

    typedef enum logic {
        regDstRt = 1'b0,
        regDstRd = 1'b1
    } regDstT;

    typedef enum logic [1:0] {
        memAluOut = 2'b00,
        memHi     = 2'b01,
        memLo     = 2'b10
    } memToRegT;

    typedef enum logic [1:0] {
        excNone      = 2'b00,
        excOverflow  = 2'b01,
        excIllegalOp = 2'b10
    } excCauseT;

    typedef enum logic [2:0] {
        uopAluReg,
        uopAluImm,
        uopMult,
        uopDiv,
        uopJr,
        uopMfhi,
        uopMflo,
        uopIllegal
    } uopKindT;

    typedef struct packed {
        uopKindT kind;
        aluOpT   aluOp;
        // Only addi traps on signed overflow
        logic    trapOverflow;
    } decodedT;

    // Control word to the datapath, all zero means idle
    typedef struct packed {
        logic     pcWrite;
        pcSrcT    pcSrc;
        aluSrcAT  aluSrcA;
        aluSrcBT  aluSrcB;
        aluOpT    aluOp;
        logic     abWrite;
        logic     aluOutWrite;
        logic     multStart;
        logic     divStart;
        logic     regWrite;
        regDstT   regDst;
        memToRegT memToReg;
        logic     hiWrite;
        logic     loWrite;
        logic     hiSrcDiv;
        logic     epcWrite;
        excCauseT excCause;
    } ctrlWordT;

endpackage

`default_nettype wire

// ==== ctrlTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_macros.svh"

module ctrlTop (
    input  wire                        Clock,
    input  wire                        rstN,
    input  wire [`CTRL_WORD_BITS-1:0]  pc,
    input  wire                        overflow,
    output logic                       wbCyc,
    output logic                       wbStb,
    output logic [`CTRL_WORD_BITS-1:0] wbAdr,
    input  wire [`CTRL_WORD_BITS-1:0]  wbDatI,
    input  wire                        wbAck,
    output ctrlPkg::ctrlWordT          ctrl
);
    import ctrlPkg::*;

    logic fetchValid;
    logic decValid;
    logic execDone;
    logic retire;
    instrT instr;
    decodedT dec;
    decodedT doneDec;
    ctrlWordT execCtrl;

    instrFetch u_fetch (
        .Clock      (Clock),
        .rstN       (rstN),
        .pc         (pc),
        .retire     (retire),
        .wbCyc      (wbCyc),
        .wbStb      (wbStb),
        .wbAdr      (wbAdr),
        .wbDatI     (wbDatI),
        .wbAck      (wbAck),
        .fetchValid (fetchValid),
        .instr      (instr)
    );

    instrDecode u_decode (
        .Clock      (Clock),
        .rstN       (rstN),
        .fetchValid (fetchValid),
        .instr      (instr),
        .decValid   (decValid),
        .dec        (dec)
    );

    execSequencer u_exec (
        .Clock    (Clock),
        .rstN     (rstN),
        .decValid (decValid),
        .dec      (dec),
        .execDone (execDone),
        .doneDec  (doneDec),
        .execCtrl (execCtrl)
    );

    resultStage u_result (
        .Clock    (Clock),
        .rstN     (rstN),
        .execDone (execDone),
        .doneDec  (doneDec),
        .execCtrl (execCtrl),
        .overflow (overflow),
        .retire   (retire),
        .ctrl     (ctrl)
    );

endmodule

`default_nettype wire

// ==== ctrl_macros.svh ====
`ifndef CTRL_MACROS_SVH
`define CTRL_MACROS_SVH

// Instruction word and PC address width
`define CTRL_WORD_BITS 32

// Multiplier start held for this many cycles
`define CTRL_MULT_CYCLES 33

// Divider start held for this many cycles
`define CTRL_DIV_CYCLES 34

// Width of the execute step counter
`define CTRL_STEP_BITS 6

`endif

// ==== execSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_macros.svh"

module execSequencer (
    input  wire                   Clock,
    input  wire                   rstN,
    input  wire                   decValid,
    input  wire ctrlPkg::decodedT dec,
    output logic                  execDone,
    output ctrlPkg::decodedT      doneDec,
    output ctrlPkg::ctrlWordT     execCtrl
);
    import ctrlPkg::*;

    localparam int MultSteps = `CTRL_MULT_CYCLES;
    localparam int DivSteps = `CTRL_DIV_CYCLES;
    localparam logic [`CTRL_STEP_BITS-1:0] OneStep = {{(`CTRL_STEP_BITS-1){1'b0}}, 1'b1};

    logic busy;
    logic [`CTRL_STEP_BITS-1:0] stepsLeft;

    // Execute steps that follow the read step
    function automatic logic [`CTRL_STEP_BITS-1:0] execSteps(uopKindT kind);
        logic [`CTRL_STEP_BITS-1:0] n;
        case (kind)
            uopAluReg, uopAluImm, uopJr: n = OneStep;
            uopMult: n = MultSteps[`CTRL_STEP_BITS-1:0];
            uopDiv:  n = DivSteps[`CTRL_STEP_BITS-1:0];
            default: n = '0;
        endcase
        return n;
    endfunction

    // PC + 4 and A/B register load
    function automatic ctrlWordT readStepWord();
        ctrlWordT word;
        word = '0;
        word.pcWrite = 1'b1;
        word.pcSrc = pcSrcAluResult;
        word.abWrite = 1'b1;
        word.aluSrcA = srcAPc;
        word.aluSrcB = srcBFour;
        word.aluOp = aluAdd;
        return word;
    endfunction

    function automatic ctrlWordT execStepWord(decodedT d);
        ctrlWordT word;
        word = '0;
        case (d.kind)
            uopAluReg, uopAluImm: begin
                word.aluSrcA = srcARegA;
                word.aluSrcB = (d.kind == uopAluImm) ? srcBSignImm : srcBRegB;
                word.aluOp = d.aluOp;
                word.aluOutWrite = 1'b1;
            end
            uopJr: begin
                word.aluSrcA = srcARegA;
                word.aluOp = aluPass;
                word.pcSrc = pcSrcAluResult;
                word.pcWrite = 1'b1;
            end
            uopMult: word.multStart = 1'b1;
            uopDiv:  word.divStart = 1'b1;
            default: word.pcWrite = 1'b0;
        endcase
        return word;
    endfunction

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            busy <= 1'b0;
            stepsLeft <= '0;
            execDone <= 1'b0;
            execCtrl <= '0;
        end else if (decValid) begin
            busy <= 1'b1;
            stepsLeft <= execSteps(dec.kind);
            if (dec.kind == uopIllegal) begin
                // Straight to the exception cycle
                execCtrl <= '0;
                execDone <= 1'b1;
            end else begin
                execCtrl <= readStepWord();
                execDone <= (execSteps(dec.kind) == '0);
            end
        end else if (busy && stepsLeft != '0) begin
            execCtrl <= execStepWord(doneDec);
            execDone <= (stepsLeft == OneStep);
            stepsLeft <= stepsLeft - OneStep;
        end else begin
            busy <= 1'b0;
            execCtrl <= '0;
            execDone <= 1'b0;
        end
    end

    // Held for the whole sequence and the result cycle
    always_ff @(posedge Clock) begin
        if (decValid) begin
            doneDec <= dec;
        end
    end

    aNoOverlap: assert property (@(posedge Clock) disable iff (!rstN)
        decValid |-> !busy)
        else $error("decValid arrived during a running sequence");

endmodule

`default_nettype wire

// ==== instrDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrDecode (
    input  wire                   Clock,
    input  wire                   rstN,
    input  wire                   fetchValid,
    input  wire ctrlPkg::instrT   instr,
    output logic                  decValid,
    output ctrlPkg::decodedT      dec
);
    import ctrlPkg::*;

    function automatic decodedT decodeSpecial(functT funct);
        decodedT d;
        d.trapOverflow = 1'b0;
        d.aluOp = aluPass;
        case (funct)
            fnAdd: begin
                d.kind = uopAluReg;
                d.aluOp = aluAdd;
            end
            fnSub: begin
                d.kind = uopAluReg;
                d.aluOp = aluSub;
            end
            fnAnd: begin
                d.kind = uopAluReg;
                d.aluOp = aluAnd;
            end
            fnSlt: begin
                d.kind = uopAluReg;
                d.aluOp = aluSlt;
            end
            fnMult: d.kind = uopMult;
            fnDiv:  d.kind = uopDiv;
            fnJr:   d.kind = uopJr;
            fnMfhi: d.kind = uopMfhi;
            fnMflo: d.kind = uopMflo;
            default: d.kind = uopIllegal;
        endcase
        return d;
    endfunction

    function automatic decodedT decodeInstr(instrT i);
        decodedT d;
        case (i.opcode)
            opSpecial: d = decodeSpecial(i.funct);
            opAddi: begin
                d.kind = uopAluImm;
                d.aluOp = aluAdd;
                d.trapOverflow = 1'b1;
            end
            opAddiu: begin
                d.kind = uopAluImm;
                d.aluOp = aluAdd;
                d.trapOverflow = 1'b0;
            end
            default: begin
                d.kind = uopIllegal;
                d.aluOp = aluPass;
                d.trapOverflow = 1'b0;
            end
        endcase
        return d;
    endfunction

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            decValid <= 1'b0;
        end else begin
            decValid <= fetchValid;
        end
    end

    always_ff @(posedge Clock) begin
        if (fetchValid) begin
            dec <= decodeInstr(instr);
        end
    end

endmodule

`default_nettype wire

// ==== instrFetch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_macros.svh"

module instrFetch (
    input  wire                        Clock,
    input  wire                        rstN,
    input  wire [`CTRL_WORD_BITS-1:0]  pc,
    input  wire                        retire,
    output logic                       wbCyc,
    output logic                       wbStb,
    output logic [`CTRL_WORD_BITS-1:0] wbAdr,
    input  wire [`CTRL_WORD_BITS-1:0]  wbDatI,
    input  wire                        wbAck,
    output logic                       fetchValid,
    output ctrlPkg::instrT             instr
);
    import ctrlPkg::*;

    typedef enum logic {
        fetchIdle,
        fetchReq
    } fetchStateT;

    fetchStateT state;
    logic startPending;
    logic startReq;
    logic ackTaken;

    // First fetch after reset, then one per retired instruction
    assign startReq = (state == fetchIdle) && (startPending || retire);
    assign ackTaken = (state == fetchReq) && wbAck;

    assign wbCyc = (state == fetchReq);
    assign wbStb = (state == fetchReq);

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            state <= fetchIdle;
            startPending <= 1'b1;
            fetchValid <= 1'b0;
        end else begin
            fetchValid <= ackTaken;
            if (startReq) begin
                state <= fetchReq;
                startPending <= 1'b0;
            end else if (ackTaken) begin
                state <= fetchIdle;
            end
        end
    end

    // Address latched once per request, word latched on the ack
    always_ff @(posedge Clock) begin
        if (startReq) begin
            wbAdr <= pc;
        end
        if (ackTaken) begin
            instr <= instrT'(wbDatI);
        end
    end

    aStableRequest: assert property (@(posedge Clock) disable iff (!rstN)
        (wbStb && !wbAck) |=> (wbStb && $stable(wbAdr)))
        else $error("wbAdr or wbStb changed before wbAck");

endmodule

`default_nettype wire

// ==== resultStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module resultStage (
    input  wire                    Clock,
    input  wire                    rstN,
    input  wire                    execDone,
    input  wire ctrlPkg::decodedT  doneDec,
    input  wire ctrlPkg::ctrlWordT execCtrl,
    input  wire                    overflow,
    output logic                   retire,
    output ctrlPkg::ctrlWordT      ctrl
);
    import ctrlPkg::*;

    ctrlWordT resultCtrl;

    // Save PC to EPC and jump to the handler
    function automatic ctrlWordT excWord(excCauseT cause);
        ctrlWordT word;
        word = '0;
        word.epcWrite = 1'b1;
        word.pcWrite = 1'b1;
        word.pcSrc = pcSrcExcVector;
        word.excCause = cause;
        return word;
    endfunction

    function automatic ctrlWordT resultWord(decodedT d, logic ovf);
        ctrlWordT word;
        word = '0;
        case (d.kind)
            uopAluReg: begin
                word.regWrite = 1'b1;
                word.regDst = regDstRd;
                word.memToReg = memAluOut;
            end
            uopAluImm: begin
                if (d.trapOverflow && ovf) begin
                    word = excWord(excOverflow);
                end else begin
                    word.regWrite = 1'b1;
                    word.regDst = regDstRt;
                    word.memToReg = memAluOut;
                end
            end
            uopMult, uopDiv: begin
                word.hiWrite = 1'b1;
                word.loWrite = 1'b1;
                word.hiSrcDiv = (d.kind == uopDiv);
            end
            uopMfhi, uopMflo: begin
                word.regWrite = 1'b1;
                word.regDst = regDstRd;
                word.memToReg = (d.kind == uopMfhi) ? memHi : memLo;
            end
            uopIllegal: word = excWord(excIllegalOp);
            // jr finished in its execute step
            default: ;
        endcase
        return word;
    endfunction

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            retire <= 1'b0;
            resultCtrl <= '0;
        end else begin
            retire <= execDone;
            if (execDone) begin
                resultCtrl <= resultWord(doneDec, overflow);
            end else begin
                resultCtrl <= '0;
            end
        end
    end

    assign ctrl = ctrlWordT'(execCtrl | resultCtrl);

    aWriteOrTrap: assert property (@(posedge Clock) disable iff (!rstN)
        !(ctrl.regWrite && ctrl.epcWrite))
        else $error("regWrite and epcWrite high together");

endmodule

`default_nettype wire

// ==== runSim.sh ====
#!/usr/bin/env bash
# Build and run the control unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f build.f --top-module tbCtrlTop -o simCtrl

./obj_dir/simCtrl | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi
echo "Simulation finished, log in sim.log"

// ==== tbCtrlTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_macros.svh"

module tbCtrlTop;
    import ctrlPkg::*;

    localparam int MaxCycles = 2000;

    logic Clock;
    logic rstN;
    logic [`CTRL_WORD_BITS-1:0] pc;
    logic overflow;
    logic wbCyc;
    logic wbStb;
    logic [`CTRL_WORD_BITS-1:0] wbAdr;
    logic [`CTRL_WORD_BITS-1:0] wbDatI;
    logic wbAck;
    ctrlWordT ctrl;

    // Program and the expected decode of each entry
    logic [`CTRL_WORD_BITS-1:0] wordList[$];
    uopKindT kindList[$];
    aluOpT opList[$];
    logic trapList[$];
    int ovfList[$];
    string nameList[$];

    // Instruction in flight
    uopKindT curKind;
    aluOpT curAluOp;
    logic curTrap;
    int curOvf;
    int curIdx;
    int nextIdx;
    int waitLeft;
    logic reqSeen;

    logic [7:0] ackAge;
    logic [7:0] resultAge;
    logic ovfSeen;
    ctrlWordT expCtrl;
    int errorCount;
    int errorMark;
    int doneCount;
    int cycleCount;
    int seedValue;

    ctrlTop u_dut (
        .Clock    (Clock),
        .rstN     (rstN),
        .pc       (pc),
        .overflow (overflow),
        .wbCyc    (wbCyc),
        .wbStb    (wbStb),
        .wbAdr    (wbAdr),
        .wbDatI   (wbDatI),
        .wbAck    (wbAck),
        .ctrl     (ctrl)
    );

    initial Clock = 1'b0;
    always #50 Clock = ~Clock;

    function automatic logic [7:0] stepsFor(uopKindT kind);
        case (kind)
            uopAluReg, uopAluImm, uopJr: return 8'd1;
            uopMult: return 8'(`CTRL_MULT_CYCLES);
            uopDiv: return 8'(`CTRL_DIV_CYCLES);
            default: return 8'd0;
        endcase
    endfunction

    function automatic logic [31:0] rType(logic [5:0] funct, logic [4:0] rs, logic [4:0] rd);
        return {6'b000000, rs, 5'd2, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] iType(logic [5:0] op, logic [4:0] rt, logic [15:0] imm);
        return {op, 5'd4, rt, imm};
    endfunction

    // ovfMode 0 or 1 forces overflow, 2 leaves it random
    task automatic addInstr(
        input logic [31:0] word,
        input uopKindT kind,
        input aluOpT op,
        input logic trap,
        input int ovfMode,
        input string name
    );
        wordList.push_back(word);
        kindList.push_back(kind);
        opList.push_back(op);
        trapList.push_back(trap);
        ovfList.push_back(ovfMode);
        nameList.push_back(name);
    endtask

    task automatic buildProgram();
        addInstr(rType(6'b100000, 5'd1, 5'd3), uopAluReg, aluAdd, 1'b0, 2, "add");
        addInstr(rType(6'b100010, 5'd1, 5'd5), uopAluReg, aluSub, 1'b0, 2, "sub");
        addInstr(rType(6'b100100, 5'd6, 5'd7), uopAluReg, aluAnd, 1'b0, 2, "and");
        addInstr(rType(6'b101010, 5'd8, 5'd9), uopAluReg, aluSlt, 1'b0, 2, "slt");
        addInstr(iType(6'b001000, 5'd10, 16'h7fff), uopAluImm, aluAdd, 1'b1, 1, "addi trap");
        addInstr(iType(6'b001000, 5'd11, 16'hfff0), uopAluImm, aluAdd, 1'b1, 0, "addi");
        addInstr(iType(6'b001001, 5'd12, 16'h7fff), uopAluImm, aluAdd, 1'b0, 1, "addiu");
        addInstr(rType(6'b011000, 5'd1, 5'd0), uopMult, aluPass, 1'b0, 2, "mult");
        addInstr(rType(6'b011010, 5'd1, 5'd0), uopDiv, aluPass, 1'b0, 2, "div");
        addInstr(rType(6'b010000, 5'd0, 5'd13), uopMfhi, aluPass, 1'b0, 2, "mfhi");
        addInstr(rType(6'b010010, 5'd0, 5'd14), uopMflo, aluPass, 1'b0, 2, "mflo");
        addInstr(rType(6'b001000, 5'd31, 5'd0), uopJr, aluPass, 1'b0, 2, "jr");
        addInstr(iType(6'b000010, 5'd0, 16'h0040), uopIllegal, aluPass, 1'b0, 2, "bad opcode");
        addInstr(rType(6'b000000, 5'd0, 5'd3), uopIllegal, aluPass, 1'b0, 2, "bad funct");
        addInstr(iType(6'b001000, 5'd15, 16'h0004), uopAluImm, aluAdd, 1'b1, 2, "addi random");
        addInstr(rType(6'b101010, 5'd3, 5'd16), uopAluReg, aluSlt, 1'b0, 2, "slt again");
    endtask

    // Read step at age 3, execute steps next, then the result cycle
    assign resultAge = 8'd4 + stepsFor(curKind);

    always_comb begin
        expCtrl = '0;
        if (ackAge == 8'd3 && curKind != uopIllegal) begin
            expCtrl.pcWrite = 1'b1;
            expCtrl.pcSrc = pcSrcAluResult;
            expCtrl.abWrite = 1'b1;
            expCtrl.aluSrcA = srcAPc;
            expCtrl.aluSrcB = srcBFour;
            expCtrl.aluOp = aluAdd;
        end else if (ackAge >= 8'd4 && ackAge < resultAge) begin
            case (curKind)
                uopAluReg, uopAluImm: begin
                    expCtrl.aluSrcA = srcARegA;
                    expCtrl.aluSrcB = (curKind == uopAluImm) ? srcBSignImm : srcBRegB;
                    expCtrl.aluOp = curAluOp;
                    expCtrl.aluOutWrite = 1'b1;
                end
                uopJr: begin
                    expCtrl.pcWrite = 1'b1;
                    expCtrl.aluSrcA = srcARegA;
                    expCtrl.aluOp = aluPass;
                end
                uopMult: expCtrl.multStart = 1'b1;
                uopDiv: expCtrl.divStart = 1'b1;
                default: expCtrl.pcWrite = 1'b0;
            endcase
        end else if (ackAge == resultAge) begin
            if (curKind == uopIllegal || (curTrap && ovfSeen)) begin
                expCtrl.epcWrite = 1'b1;
                expCtrl.pcWrite = 1'b1;
                expCtrl.pcSrc = pcSrcExcVector;
                expCtrl.excCause = (curKind == uopIllegal) ? excIllegalOp : excOverflow;
            end else if (curKind == uopMult || curKind == uopDiv) begin
                expCtrl.hiWrite = 1'b1;
                expCtrl.loWrite = 1'b1;
                expCtrl.hiSrcDiv = (curKind == uopDiv);
            end else if (curKind != uopJr) begin
                expCtrl.regWrite = 1'b1;
                expCtrl.regDst = (curKind == uopAluImm) ? regDstRt : regDstRd;
                expCtrl.memToReg = (curKind == uopMfhi) ? memHi :
                                   (curKind == uopMflo) ? memLo : memAluOut;
            end
        end
    end

    always @(posedge Clock) begin
        if (!rstN) begin
            ackAge <= 8'd0;
        end else if (wbCyc && wbStb && wbAck) begin
            // nextIdx already points past the word being acked
            ackAge <= 8'd1;
            curIdx <= nextIdx - 1;
            curKind <= kindList[nextIdx - 1];
            curAluOp <= opList[nextIdx - 1];
            curTrap <= trapList[nextIdx - 1];
            curOvf <= ovfList[nextIdx - 1];
        end else if (ackAge != 8'd0 && ackAge != 8'hff) begin
            ackAge <= ackAge + 8'd1;
        end
        // Overflow as seen at the last execute edge
        if (ackAge == resultAge - 8'd1) begin
            ovfSeen <= overflow;
        end
        cycleCount <= cycleCount + 1;
        if (cycleCount >= MaxCycles) begin
            $display("Timeout: run did not finish within %0d cycles", MaxCycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // Wishbone memory with random wait states
    always @(negedge Clock) begin
        if (rstN) begin
            if (ackAge == resultAge + 8'd1) begin
                $display("test %0d %s finished, %0d errors", curIdx, nameList[curIdx],
                         errorCount - errorMark);
                errorMark = errorCount;
                doneCount++;
            end
            overflow = (curOvf == 2) ? 1'($urandom_range(0, 1)) : curOvf[0];
            if (wbAck) begin
                wbAck = 1'b0;
                pc = $urandom() & 32'hffff_fffc;
            end else if (wbCyc && wbStb && nextIdx < wordList.size()) begin
                if (!reqSeen) begin
                    reqSeen = 1'b1;
                    waitLeft = $urandom_range(0, 3);
                end
                if (waitLeft == 0) begin
                    wbDatI = wordList[nextIdx];
                    wbAck = 1'b1;
                    reqSeen = 1'b0;
                    nextIdx++;
                end else begin
                    waitLeft--;
                end
            end
        end
    end

    aFetchAddr: assert property (@(posedge Clock) disable iff (!rstN)
        wbCyc |-> (wbStb && wbAdr == pc))
        else begin
            errorCount++;
            $display("[ERROR] %0t wbAdr expected %h actual %h", $time, $sampled(pc),
                     $sampled(wbAdr));
        end

    aFetchDrop: assert property (@(posedge Clock) disable iff (!rstN)
        (wbCyc && wbAck) |=> (!wbCyc && !wbStb))
        else begin
            errorCount++;
            $display("At %0t the fetch request stayed open after its ack", $time);
        end

    aFetchWait: assert property (@(posedge Clock) disable iff (!rstN)
        (ackAge != 8'd0 && ackAge <= resultAge) |-> !wbCyc)
        else begin
            errorCount++;
            $display("At %0t a fetch started before the instruction retired", $time);
        end

    aFetchStart: assert property (@(posedge Clock) disable iff (!rstN)
        (ackAge == resultAge + 8'd1) |-> wbCyc)
        else begin
            errorCount++;
            $display("At %0t no fetch started in the cycle after retire", $time);
        end

    aQuiet: assert property (@(posedge Clock) disable iff (!rstN)
        (ackAge < 8'd3 || ackAge > resultAge || (ackAge == 8'd3 && curKind == uopIllegal))
        |-> ctrl == '0)
        else begin
            errorCount++;
            $display("[ERROR] %0t ctrl expected %h actual %h", $time, 24'h0, $sampled(ctrl));
        end

    aReadStep: assert property (@(posedge Clock) disable iff (!rstN)
        (ackAge == 8'd3 && curKind != uopIllegal) |-> ctrl == expCtrl)
        else begin
            errorCount++;
            $display("[ERROR] %0t ctrl expected %h actual %h", $time, $sampled(expCtrl),
                     $sampled(ctrl));
        end

    aExecStep: assert property (@(posedge Clock) disable iff (!rstN)
        (ackAge >= 8'd4 && ackAge < resultAge) |-> ctrl == expCtrl)
        else begin
            errorCount++;
            $display("[ERROR] %0t ctrl expected %h actual %h", $time, $sampled(expCtrl),
                     $sampled(ctrl));
        end

    aResult: assert property (@(posedge Clock) disable iff (!rstN)
        (ackAge == resultAge) |-> ctrl == expCtrl)
        else begin
            errorCount++;
            $display("[ERROR] %0t ctrl expected %h actual %h", $time, $sampled(expCtrl),
                     $sampled(ctrl));
        end

    initial begin
        seedValue = $urandom(62768);
        rstN = 1'b0;
        pc = $urandom() & 32'hffff_fffc;
        overflow = 1'b0;
        wbDatI = '0;
        wbAck = 1'b0;
        curKind = uopAluReg;
        curAluOp = aluPass;
        curTrap = 1'b0;
        curOvf = 0;
        curIdx = 0;
        nextIdx = 0;
        waitLeft = 0;
        reqSeen = 1'b0;
        ovfSeen = 1'b0;
        errorCount = 0;
        errorMark = 0;
        doneCount = 0;
        cycleCount = 0;
        buildProgram();
        repeat (4) @(negedge Clock);
        rstN = 1'b1;
        wait (doneCount == wordList.size());
        repeat (3) @(negedge Clock);
        $display("tests run %0d, errors %0d", doneCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
